// File: hw/ethernet_sdr_config.svh
`ifndef ETHERNET_SDR_CONFIG_SVH
`define ETHERNET_SDR_CONFIG_SVH

// stream and frame geometry
`define NUM_STREAMS 4
`define PAYLOAD_BYTES 16
`define HDR_BYTES 8

// udp port for data and commands
`define CMD_PORT 16'd1024

// packet sync and type bytes
`define SYNC0 8'hEF
`define SYNC1 8'hFE
`define TYPE_DATA 8'h01
`define TYPE_DISC 8'h02
`define TYPE_RUN 8'h04

// network_state[3:1] while running
`define NET_RUNNING 3'b100

`endif

// File: hw/udp_frame_pkg.sv
package udp_frame_pkg;

	// udp receive stream from the network stack
	typedef struct packed {
		logic        active;
		logic [7:0]  data;
		logic [15:0] to_port;
		logic        broadcast;
	} udp_rx_t;

	// udp transmit request towards the network stack
	typedef struct packed {
		logic        request;
		logic [7:0]  data;
		logic [10:0] length;
	} udp_tx_t;

	// receive fifo write port
	typedef struct packed {
		logic       enable;
		logic [7:0] data;
	} rx_fifo_t;

endpackage

// File: hw/sdr_stream_pkg.sv
`include "ethernet_sdr_config.svh"

package sdr_stream_pkg;

	localparam int STREAM_W = (`NUM_STREAMS > 1) ? $clog2(`NUM_STREAMS) : 1;
	localparam int RD_W = $clog2(`PAYLOAD_BYTES);

	typedef logic [STREAM_W-1:0] stream_id_t;

	// sample byte tagged with its stream
	typedef struct packed {
		stream_id_t id;
		logic [7:0] data;
	} sample_byte_t;

	// byte index into a framer payload
	typedef logic [RD_W-1:0] framer_rd_t;

endpackage

// File: hw/rx_recv.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module rx_recv (
	input  logic                  tx_clock,
	input  logic                  rst_n_i,
	input  udp_frame_pkg::udp_rx_t  udp_rx_i,
	output udp_frame_pkg::rx_fifo_t rx_fifo_o,
	output logic                  run_o,
	output logic                  disc_req_o
);

	import udp_frame_pkg::*;

	localparam logic [3:0] HDR_IDX = 4'(`HDR_BYTES);

	udp_rx_t    rx_q;
	logic [3:0] idx;
	logic       sync0_ok;
	logic       sync1_ok;
	logic [7:0] type_q;
	logic       arg_q;
	logic       hdr_ok;
	logic       is_data;
	logic       pkt_end;

	assign hdr_ok  = sync0_ok && sync1_ok;
	assign pkt_end = rx_q.active && !udp_rx_i.active;
	assign is_data = hdr_ok && (type_q == `TYPE_DATA) && (udp_rx_i.to_port == `CMD_PORT);

	// header bytes of the current packet
	always_ff @(posedge tx_clock) begin
		if (!udp_rx_i.active) begin
			sync0_ok <= 1'b0;
			sync1_ok <= 1'b0;
			type_q   <= 8'h00;
		end else begin
			if (idx == 4'd0) sync0_ok <= (udp_rx_i.data == `SYNC0);
			if (idx == 4'd1) sync1_ok <= (udp_rx_i.data == `SYNC1);
			if (idx == 4'd2) type_q <= udp_rx_i.data;
			if (idx == 4'd3) arg_q <= udp_rx_i.data[0];
		end
	end

	always_ff @(posedge tx_clock) begin
		rx_fifo_o.data <= udp_rx_i.data;
		if (!rst_n_i) begin
			rx_q             <= '0;
			idx              <= 4'd0;
			run_o            <= 1'b0;
			disc_req_o       <= 1'b0;
			rx_fifo_o.enable <= 1'b0;
		end else begin
			rx_q <= udp_rx_i;
			// index saturates once the header is past
			if (!udp_rx_i.active) idx <= 4'd0;
			else if (idx != HDR_IDX) idx <= idx + 4'd1;
			rx_fifo_o.enable <= udp_rx_i.active && (idx == HDR_IDX) && is_data;
			// act on the packet once active falls
			disc_req_o <= pkt_end && rx_q.broadcast && hdr_ok && (type_q == `TYPE_DISC);
			if (pkt_end && hdr_ok && (type_q == `TYPE_RUN) && (rx_q.to_port == `CMD_PORT))
				run_o <= arg_q;
		end
	end

	a_port_stable: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		rx_q.active && udp_rx_i.active |-> udp_rx_i.to_port == rx_q.to_port);

endmodule

// File: hw/stream_router.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module stream_router (
	input  logic                        tx_clock,
	input  logic                        rst_n_i,
	input  logic                        sample_stb_i,
	input  sdr_stream_pkg::sample_byte_t sample_i,
	output logic [`NUM_STREAMS-1:0]     stb_o,
	output logic [7:0]                  data_o
);

	import sdr_stream_pkg::*;

	logic         stb_q;
	sample_byte_t sample_q;

	always_ff @(posedge tx_clock) begin
		if (!rst_n_i) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= sample_stb_i;
		end
	end

	always_ff @(posedge tx_clock) begin
		if (sample_stb_i) sample_q <= sample_i;
	end

	// one-hot strobe to the tagged framer
	always_comb begin
		for (int s = 0; s < `NUM_STREAMS; s++) begin
			stb_o[s] = stb_q && (sample_q.id == stream_id_t'(s));
		end
	end

	assign data_o = sample_q.data;

	a_id_range: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		sample_stb_i |-> int'(sample_i.id) < `NUM_STREAMS);

endmodule

// File: hw/stream_framer.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module stream_framer (
	input  logic                      tx_clock,
	input  logic                      rst_n_i,
	input  logic                      stb_i,
	input  logic [7:0]                data_i,
	input  sdr_stream_pkg::framer_rd_t rd_i,
	input  logic                      done_i,
	output logic                      ready_o,
	output logic [7:0]                rd_data_o,
	output logic [31:0]               seq_o,
	output logic                      overflow_o
);

	import sdr_stream_pkg::*;

	localparam framer_rd_t LAST = framer_rd_t'(`PAYLOAD_BYTES - 1);

	logic [7:0] payload [`PAYLOAD_BYTES];
	framer_rd_t wr_idx;
	logic       wr_en;

	// bytes are taken only while no frame is waiting
	assign wr_en = stb_i && !ready_o;

	always_ff @(posedge tx_clock) begin
		if (wr_en) payload[wr_idx] <= data_i;
	end

	always_ff @(posedge tx_clock) begin
		if (!rst_n_i) begin
			wr_idx     <= '0;
			ready_o    <= 1'b0;
			seq_o      <= 32'd0;
			overflow_o <= 1'b0;
		end else begin
			if (wr_en) begin
				if (wr_idx == LAST) begin
					wr_idx  <= '0;
					ready_o <= 1'b1;
				end else begin
					wr_idx <= wr_idx + 1'b1;
				end
			end
			if (stb_i && ready_o) overflow_o <= 1'b1;
			// frame drained by the arbiter
			if (done_i) begin
				ready_o <= 1'b0;
				seq_o   <= seq_o + 32'd1;
			end
		end
	end

	assign rd_data_o = payload[rd_i];

	a_done_ready: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		done_i |-> ready_o);

	a_ovf_sticky: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		overflow_o |=> overflow_o);

endmodule

// File: hw/udp_tx_arbiter.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module udp_tx_arbiter (
	input  logic                                tx_clock,
	input  logic                                rst_n_i,
	input  logic [3:0]                          network_state_i,
	input  logic [47:0]                         this_mac_i,
	input  logic                                run_i,
	input  logic                                disc_req_i,
	input  logic [`NUM_STREAMS-1:0]             ready_i,
	input  logic [`NUM_STREAMS-1:0][7:0]        rd_data_i,
	input  logic [`NUM_STREAMS-1:0][31:0]       seq_i,
	input  logic                                udp_tx_enable_i,
	output udp_frame_pkg::udp_tx_t              udp_tx_o,
	output sdr_stream_pkg::framer_rd_t          rd_o,
	output logic [`NUM_STREAMS-1:0]             done_o
);

	import sdr_stream_pkg::*;

	localparam logic [10:0] FRAME_LEN = 11'(`HDR_BYTES + `PAYLOAD_BYTES);
	localparam logic [10:0] DISC_LEN = 11'd10;

	logic                    net_ok;
	logic                    busy;
	logic                    is_disc;
	logic                    disc_pend;
	logic [4:0]              pos;
	stream_id_t              sel;
	stream_id_t              rr_ptr;
	stream_id_t              pick;
	logic                    pick_ok;
	logic [`NUM_STREAMS-1:0] eligible;
	logic                    adv;
	logic                    last;
	logic [7:0]              tx_byte;

	// transmit only while the network is in its running state
	assign net_ok = network_state_i[3:1] == `NET_RUNNING;

	// a stream being released this cycle still shows ready
	assign eligible = ready_i & ~done_o;

	always_comb begin
		int cand;
		pick_ok = 1'b0;
		pick    = rr_ptr;
		for (int k = 0; k < `NUM_STREAMS; k++) begin
			cand = (int'(rr_ptr) + k) % `NUM_STREAMS;
			if (!pick_ok && eligible[cand]) begin
				pick_ok = 1'b1;
				pick    = stream_id_t'(cand);
			end
		end
	end

	// header bytes by position and payload after them
	always_comb begin
		case (pos)
			5'd0: tx_byte = `SYNC0;
			5'd1: tx_byte = `SYNC1;
			5'd2: tx_byte = is_disc ? `TYPE_DISC : `TYPE_DATA;
			5'd3: tx_byte = is_disc ? this_mac_i[47:40] : 8'(sel);
			5'd4: tx_byte = is_disc ? this_mac_i[39:32] : seq_i[sel][31:24];
			5'd5: tx_byte = is_disc ? this_mac_i[31:24] : seq_i[sel][23:16];
			5'd6: tx_byte = is_disc ? this_mac_i[23:16] : seq_i[sel][15:8];
			5'd7: tx_byte = is_disc ? this_mac_i[15:8] : seq_i[sel][7:0];
			5'd8: tx_byte = is_disc ? this_mac_i[7:0] : rd_data_i[sel];
			5'd9: tx_byte = is_disc ? {7'b0, run_i} : rd_data_i[sel];
			default: tx_byte = rd_data_i[sel];
		endcase
	end

	always_comb begin
		udp_tx_o.request = busy && net_ok;
		udp_tx_o.data    = tx_byte;
		udp_tx_o.length  = is_disc ? DISC_LEN : FRAME_LEN;
	end

	assign rd_o = framer_rd_t'(pos - 5'(`HDR_BYTES));
	assign adv  = udp_tx_o.request && udp_tx_enable_i;
	assign last = 11'(pos) == udp_tx_o.length - 11'd1;

	always_ff @(posedge tx_clock) begin
		if (!rst_n_i) begin
			busy      <= 1'b0;
			is_disc   <= 1'b0;
			disc_pend <= 1'b0;
			pos       <= 5'd0;
			sel       <= '0;
			rr_ptr    <= '0;
			done_o    <= '0;
		end else begin
			done_o <= '0;
			if (busy) begin
				if (adv) begin
					if (last) begin
						busy <= 1'b0;
						pos  <= 5'd0;
						if (!is_disc) done_o[sel] <= 1'b1;
					end else begin
						pos <= pos + 5'd1;
					end
				end
			end else if (net_ok && disc_pend) begin
				// discovery reply wins over frames
				busy      <= 1'b1;
				is_disc   <= 1'b1;
				disc_pend <= 1'b0;
			end else if (net_ok && run_i && pick_ok) begin
				busy    <= 1'b1;
				is_disc <= 1'b0;
				sel     <= pick;
				rr_ptr  <= stream_id_t'((int'(pick) + 1) % `NUM_STREAMS);
			end
			if (disc_req_i) disc_pend <= 1'b1;
		end
	end

	a_len_stable: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		udp_tx_o.request |=> !udp_tx_o.request || $stable(udp_tx_o.length));

endmodule

// File: hw/ethernet_sdr.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module ethernet_sdr (
	input  logic                        tx_clock,
	input  logic                        rst_n_i,
	input  udp_frame_pkg::udp_rx_t      udp_rx_i,
	input  logic                        udp_tx_enable_i,
	input  logic [3:0]                  network_state_i,
	input  logic [47:0]                 this_mac_i,
	input  logic                        sample_stb_i,
	input  sdr_stream_pkg::sample_byte_t sample_i,
	output udp_frame_pkg::udp_tx_t      udp_tx_o,
	output udp_frame_pkg::rx_fifo_t     rx_fifo_o,
	output logic                        run_o,
	output logic [`NUM_STREAMS-1:0]     overflow_o
);

	import sdr_stream_pkg::*;

	logic                          disc_req;
	logic [`NUM_STREAMS-1:0]       stb;
	logic [7:0]                    data;
	framer_rd_t                    rd;
	logic [`NUM_STREAMS-1:0]       ready;
	logic [`NUM_STREAMS-1:0][7:0]  rd_data;
	logic [`NUM_STREAMS-1:0][31:0] seq;
	logic [`NUM_STREAMS-1:0]       done;

	rx_recv u_rx_recv (
		.tx_clock   (tx_clock),
		.rst_n_i    (rst_n_i),
		.udp_rx_i   (udp_rx_i),
		.rx_fifo_o  (rx_fifo_o),
		.run_o      (run_o),
		.disc_req_o (disc_req)
	);

	stream_router u_router (
		.tx_clock     (tx_clock),
		.rst_n_i      (rst_n_i),
		.sample_stb_i (sample_stb_i),
		.sample_i     (sample_i),
		.stb_o        (stb),
		.data_o       (data)
	);

	// one framer per sample stream
	for (genvar s = 0; s < `NUM_STREAMS; s++) begin : g_framer
		stream_framer u_framer (
			.tx_clock   (tx_clock),
			.rst_n_i    (rst_n_i),
			.stb_i      (stb[s]),
			.data_i     (data),
			.rd_i       (rd),
			.done_i     (done[s]),
			.ready_o    (ready[s]),
			.rd_data_o  (rd_data[s]),
			.seq_o      (seq[s]),
			.overflow_o (overflow_o[s])
		);
	end

	udp_tx_arbiter u_arbiter (
		.tx_clock        (tx_clock),
		.rst_n_i         (rst_n_i),
		.network_state_i (network_state_i),
		.this_mac_i      (this_mac_i),
		.run_i           (run_o),
		.disc_req_i      (disc_req),
		.ready_i         (ready),
		.rd_data_i       (rd_data),
		.seq_i           (seq),
		.udp_tx_enable_i (udp_tx_enable_i),
		.udp_tx_o        (udp_tx_o),
		.rd_o            (rd),
		.done_o          (done)
	);

endmodule

// File: dv/ethernet_sdr_tb.sv
`timescale 1ns/1ps
`include "ethernet_sdr_config.svh"

module ethernet_sdr_tb;

	import udp_frame_pkg::*;
	import sdr_stream_pkg::*;

	localparam logic [3:0] NET_UP = {`NET_RUNNING, 1'b0};

	logic                    tx_clock = 1'b0;
	logic                    rst_n_i;
	udp_rx_t                 udp_rx_i;
	logic                    udp_tx_enable_i = 1'b0;
	logic [3:0]              network_state_i;
	logic [47:0]             this_mac_i;
	logic                    sample_stb_i;
	sample_byte_t            sample_i;
	udp_tx_t                 udp_tx_o;
	rx_fifo_t                rx_fifo_o;
	logic                    run_o;
	logic [`NUM_STREAMS-1:0] overflow_o;

	// expected transmit bytes and packet lengths
	logic [7:0]              exp_q[$];
	logic [10:0]             len_q[$];
	logic [7:0]              pkt[$];
	logic [7:0]              rx_pkt[$];
	logic [7:0]              pl [`NUM_STREAMS][`PAYLOAD_BYTES+1];
	logic [31:0]             seq_model [`NUM_STREAMS];
	int                      exp_cnt = 0;
	logic [7:0]              exp_byte = 8'h00;
	logic [10:0]             exp_len = 11'd0;
	logic                    exp_run = 1'b0;
	logic                    fwd_exp = 1'b0;
	logic [`NUM_STREAMS-1:0] exp_ovf = '0;
	logic                    hold = 1'b0;
	logic                    run_exp_q = 1'b0;
	logic                    fwd_q = 1'b0;
	logic [7:0]              rx_data_q = 8'h00;
	logic [`NUM_STREAMS-1:0] ovf_q1 = '0;
	logic [`NUM_STREAMS-1:0] ovf_q2 = '0;
	logic [31:0]             data_state = 32'd44;
	logic [31:0]             bp_state = 32'd44;
	int                      pkt_pos = 0;
	int                      tx_bytes = 0;
	int                      fifo_bytes = 0;
	int                      errors = 0;
	logic                    tx_adv;

	ethernet_sdr DUT (.*);

	always #2 tx_clock = ~tx_clock;

	assign tx_adv = udp_tx_o.request && udp_tx_enable_i;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] next_byte();
		data_state = lcg_step(data_state);
		return data_state[23:16];
	endfunction

	// random back-pressure with enable high about three cycles in four
	always @(posedge tx_clock) begin
		#1;
		bp_state = lcg_step(bp_state);
		udp_tx_enable_i = bp_state[18] | bp_state[19];
	end

	// consume one expected byte per accepted transmit byte
	always @(posedge tx_clock) begin
		if (rst_n_i && tx_adv) begin
			tx_bytes++;
			pkt_pos++;
			if (exp_q.size() > 0) void'(exp_q.pop_front());
			if (len_q.size() > 0 && pkt_pos == int'(len_q[0])) begin
				void'(len_q.pop_front());
				pkt_pos = 0;
			end
			exp_cnt  <= exp_q.size();
			exp_byte <= (exp_q.size() > 0) ? exp_q[0] : 8'h00;
			exp_len  <= (len_q.size() > 0) ? len_q[0] : 11'd0;
		end
		if (rst_n_i && rx_fifo_o.enable) fifo_bytes++;
		run_exp_q <= exp_run;
		fwd_q     <= fwd_exp;
		rx_data_q <= udp_rx_i.data;
		ovf_q1    <= exp_ovf;
		ovf_q2    <= ovf_q1;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		errors++;
		$display("Fail %0t %s expected %0h got %0h", $time, name, exp, got);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge tx_clock);
		#1;
	endtask

	task automatic push_packet();
		len_q.push_back(11'(pkt.size()));
		foreach (pkt[i]) exp_q.push_back(pkt[i]);
		pkt.delete();
		exp_cnt  <= exp_q.size();
		exp_byte <= exp_q[0];
		exp_len  <= len_q[0];
	endtask

	task automatic push_frame(input int s);
		pkt.push_back(`SYNC0);
		pkt.push_back(`SYNC1);
		pkt.push_back(`TYPE_DATA);
		pkt.push_back(8'(s));
		for (int b = 3; b >= 0; b--) pkt.push_back(seq_model[s][b*8 +: 8]);
		for (int i = 0; i < `PAYLOAD_BYTES; i++) pkt.push_back(pl[s][i]);
		seq_model[s]++;
		push_packet();
	endtask

	task automatic wait_tx_drain(input int limit, input string what);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge tx_clock);
			n++;
		end
		#1;
		if (exp_q.size() != 0) begin
			report_problem($sformatf("timeout waiting for %s, %0d bytes never sent",
				what, exp_q.size()));
			exp_q.delete();
			len_q.delete();
			pkt_pos = 0;
			exp_cnt <= 0;
		end
	endtask

	task automatic rx_hdr(input logic [7:0] typ, input logic [7:0] arg);
		rx_pkt.push_back(`SYNC0);
		rx_pkt.push_back(`SYNC1);
		rx_pkt.push_back(typ);
		rx_pkt.push_back(arg);
	endtask

	// drives rx_pkt as one packet and updates the model when it ends
	task automatic send_rx(input logic [15:0] port, input logic bcast);
		logic hdr;
		logic on_port;
		hdr = rx_pkt.size() >= 4 && rx_pkt[0] == `SYNC0 && rx_pkt[1] == `SYNC1;
		on_port = port == `CMD_PORT;
		foreach (rx_pkt[i]) begin
			@(posedge tx_clock);
			#1;
			udp_rx_i = '{active: 1'b1, data: rx_pkt[i], to_port: port, broadcast: bcast};
			fwd_exp = hdr && on_port && rx_pkt[2] == `TYPE_DATA && i >= `HDR_BYTES;
		end
		@(posedge tx_clock);
		#1;
		udp_rx_i.active = 1'b0;
		fwd_exp = 1'b0;
		if (hdr && on_port && rx_pkt[2] == `TYPE_RUN) exp_run = rx_pkt[3][0];
		if (hdr && bcast && rx_pkt[2] == `TYPE_DISC) begin
			pkt.push_back(`SYNC0);
			pkt.push_back(`SYNC1);
			pkt.push_back(`TYPE_DISC);
			for (int b = 5; b >= 0; b--) pkt.push_back(this_mac_i[b*8 +: 8]);
			pkt.push_back({7'b0, exp_run});
			push_packet();
		end
		rx_pkt.delete();
	endtask

	task automatic run_cmd(input logic [15:0] port, input logic [7:0] arg);
		rx_hdr(`TYPE_RUN, arg);
		send_rx(port, 1'b0);
		idle(3);
	endtask

	task automatic data_packet(input logic [15:0] port);
		rx_hdr(`TYPE_DATA, 8'h00);
		repeat (`HDR_BYTES + 8) rx_pkt.push_back(next_byte());
		send_rx(port, 1'b0);
	endtask

	task automatic drive_sample(input int s, input logic [7:0] b);
		@(posedge tx_clock);
		#1;
		sample_stb_i = 1'b1;
		sample_i = '{id: stream_id_t'(s), data: b};
	endtask

	task automatic stop_samples();
		@(posedge tx_clock);
		#1;
		sample_stb_i = 1'b0;
	endtask

	// interleaved samples to every stream give frames in stream order
	task automatic frame_round();
		for (int s = 0; s < `NUM_STREAMS; s++) begin
			for (int i = 0; i < `PAYLOAD_BYTES; i++) pl[s][i] = next_byte();
			push_frame(s);
		end
		for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
			for (int s = 0; s < `NUM_STREAMS; s++) drive_sample(s, pl[s][i]);
		end
		stop_samples();
		wait_tx_drain(600, "frame round");
	endtask

	initial begin
		rst_n_i = 1'b0;
		udp_rx_i = '0;
		network_state_i = NET_UP;
		this_mac_i = 48'h02_1a_2b_3c_4d_5e;
		sample_stb_i = 1'b0;
		sample_i = '0;
		foreach (seq_model[s]) seq_model[s] = 32'd0;
		repeat (3) @(posedge tx_clock);
		#1;
		rst_n_i = 1'b1;
		idle(4);
		// broadcast and unicast discovery
		rx_hdr(`TYPE_DISC, 8'h00);
		send_rx(16'd5000, 1'b1);
		wait_tx_drain(200, "discovery reply");
		rx_hdr(`TYPE_DISC, 8'h00);
		send_rx(16'd5000, 1'b0);
		idle(40);
		run_cmd(`CMD_PORT, 8'h01);
		run_cmd(16'd1025, 8'h00);
		run_cmd(`CMD_PORT, 8'h00);
		run_cmd(`CMD_PORT, 8'h01);
		rx_hdr(`TYPE_DISC, 8'h00);
		send_rx(`CMD_PORT, 1'b1);
		wait_tx_drain(200, "discovery reply with run");
		data_packet(`CMD_PORT);
		data_packet(16'd2000);
		idle(4);
		frame_round();
		frame_round();
		// frame held by run low and then by network state
		run_cmd(`CMD_PORT, 8'h00);
		hold = 1'b1;
		for (int i = 0; i < `PAYLOAD_BYTES; i++) pl[2][i] = next_byte();
		push_frame(2);
		for (int i = 0; i < `PAYLOAD_BYTES; i++) drive_sample(2, pl[2][i]);
		stop_samples();
		idle(30);
		network_state_i = 4'b0010;
		run_cmd(`CMD_PORT, 8'h01);
		idle(30);
		network_state_i = NET_UP;
		hold = 1'b0;
		wait_tx_drain(300, "held frame");
		// stream 3 goes before stream 1 since stream 2 was served last
		run_cmd(`CMD_PORT, 8'h00);
		for (int i = 0; i < `PAYLOAD_BYTES; i++) pl[3][i] = next_byte();
		push_frame(3);
		// one byte too many for stream 1
		for (int i = 0; i <= `PAYLOAD_BYTES; i++) pl[1][i] = next_byte();
		push_frame(1);
		for (int i = 0; i < `PAYLOAD_BYTES; i++) drive_sample(3, pl[3][i]);
		for (int i = 0; i <= `PAYLOAD_BYTES; i++) begin
			drive_sample(1, pl[1][i]);
			if (i == `PAYLOAD_BYTES) exp_ovf[1] = 1'b1;
		end
		stop_samples();
		idle(10);
		run_cmd(`CMD_PORT, 8'h01);
		wait_tx_drain(300, "frames after overflow");
		idle(10);
		$display("tx bytes %0d, fifo bytes %0d, errors %0d", tx_bytes, fifo_bytes, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	a_tx_data: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		tx_adv |-> udp_tx_o.data == exp_byte)
		else report_mismatch("udp_tx_o.data", $sampled(exp_byte), $sampled(udp_tx_o.data));

	a_tx_len: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		udp_tx_o.request |-> udp_tx_o.length == exp_len)
		else report_mismatch("udp_tx_o.length", $sampled(exp_len), $sampled(udp_tx_o.length));

	a_tx_expected: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		udp_tx_o.request |-> exp_cnt != 0)
		else report_problem("request raised with no packet expected");

	a_tx_hold: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		hold |-> !udp_tx_o.request)
		else report_problem("request raised while run or network state forbids it");

	a_run: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		run_o == run_exp_q)
		else report_mismatch("run_o", $sampled(run_exp_q), $sampled(run_o));

	a_fifo_en: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		rx_fifo_o.enable == fwd_q)
		else report_mismatch("rx_fifo_o.enable", $sampled(fwd_q), $sampled(rx_fifo_o.enable));

	a_fifo_data: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		rx_fifo_o.enable |-> rx_fifo_o.data == rx_data_q)
		else report_mismatch("rx_fifo_o.data", $sampled(rx_data_q), $sampled(rx_fifo_o.data));

	a_ovf: assert property (@(posedge tx_clock) disable iff (!rst_n_i)
		overflow_o == ovf_q2)
		else report_mismatch("overflow_o", $sampled(ovf_q2), $sampled(overflow_o));

endmodule

// File: ethernet_sdr.f
+incdir+hw
hw/udp_frame_pkg.sv
hw/sdr_stream_pkg.sv
hw/rx_recv.sv
hw/stream_router.sv
hw/stream_framer.sv
hw/udp_tx_arbiter.sv
hw/ethernet_sdr.sv
dv/ethernet_sdr_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f ethernet_sdr.f \
	--top-module ethernet_sdr_tb -o ethernet_sdr_sim &&
./obj_dir/ethernet_sdr_sim | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
